// File: src/exec_pkg.sv
// Execute stage shared definitions
// Datapath width, operation encodings and the packets that
// travel between decode, execute and writeback

`default_nettype none

package exec_pkg;

    // --------------------
    // Widths
    // --------------------

    localparam int XLEN       = 32;                // Datapath width
    localparam int REG_ADDR_W = 5;                 // Register number width

    typedef logic [XLEN-1:0]       xword_t;        // One data word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;     // One register number

    // --------------------
    // Operation encodings
    // --------------------

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,                           // lhs + rhs
        ALU_SUB  = 4'd1,                           // lhs - rhs
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,                           // Shift left logical
        ALU_SRL  = 4'd6,                           // Shift right logical
        ALU_SRA  = 4'd7,                           // Shift right arithmetic
        ALU_SLT  = 4'd8,                           // Signed set less than
        ALU_SLTU = 4'd9                            // Unsigned set less than
    } alu_op_e;

    typedef enum logic [3:0] {
        CFU_NONE = 4'd0,                           // No control flow change
        CFU_BEQ  = 4'd1,
        CFU_BNE  = 4'd2,
        CFU_BLT  = 4'd3,
        CFU_BGE  = 4'd4,
        CFU_BLTU = 4'd5,
        CFU_BGEU = 4'd6,
        CFU_JAL  = 4'd7,                           // Always taken, pc relative
        CFU_JALR = 4'd8                            // Always taken, register based
    } cfu_op_e;

    typedef enum logic {
        WB_ALU = 1'b0,                             // Write ALU result
        WB_NPC = 1'b1                              // Write link address
    } wb_src_e;

    // --------------------
    // Stage packets
    // --------------------

    typedef struct packed {
        xword_t    pc;                             // Instruction address
        xword_t    npc;                            // Sequential next address
        reg_addr_t rd;                             // Destination register
        xword_t    lhs;                            // ALU left operand
        xword_t    rhs;                            // ALU right operand
        xword_t    imm;                            // Branch / jal offset
        alu_op_e   alu_op;
        cfu_op_e   cfu_op;
        wb_src_e   wb_src;
    } exec_req_t;

    typedef struct packed {
        logic eq;                                  // lhs == rhs
        logic lt;                                  // Signed lhs < rhs
        logic ltu;                                 // Unsigned lhs < rhs
    } cmp_flags_t;

    typedef struct packed {
        xword_t    pc;
        reg_addr_t rd;
        xword_t    wdata;                          // Register write data
        logic      cf_taken;                       // Control flow was changed
    } wb_pkt_t;

endpackage

`default_nettype wire

// File: src/exec_alu.sv
// Execute stage ALU
// Purely combinational; gives the selected result, the raw sum
// used for jalr targets and the comparison flags used by branches

`default_nettype none

module exec_alu import exec_pkg::*; (
    input  alu_op_e    alu_op,                     // Operation select
    input  xword_t     lhs,                        // Left operand
    input  xword_t     rhs,                        // Right operand
    output xword_t     result,                     // Selected result
    output xword_t     sum,                        // Always lhs + rhs
    output cmp_flags_t cmp                         // Always lhs vs rhs
);

    localparam int SHAMT_W = $clog2(XLEN);         // 5 for a 32 bit datapath

    // --------------------
    // Shared arithmetic
    // --------------------

    xword_t              diff;                     // lhs - rhs
    logic [SHAMT_W-1:0]  shamt;                    // Low bits of rhs only
    xword_t              shl;
    xword_t              shr_l;
    xword_t              shr_a;

    assign sum   = lhs + rhs;
    assign diff  = lhs - rhs;
    assign shamt = rhs[SHAMT_W-1:0];

    assign shl   = lhs << shamt;
    assign shr_l = lhs >> shamt;
    assign shr_a = xword_t'($signed(lhs) >>> shamt);  // Sign fill from bit 31

    // Flags feed the CFU regardless of alu_op
    assign cmp.eq  = (lhs == rhs);
    assign cmp.lt  = ($signed(lhs) < $signed(rhs));
    assign cmp.ltu = (lhs < rhs);

    // --------------------
    // Result select
    // --------------------

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = lhs & rhs;
            ALU_OR:   result = lhs | rhs;
            ALU_XOR:  result = lhs ^ rhs;
            ALU_SLL:  result = shl;
            ALU_SRL:  result = shr_l;
            ALU_SRA:  result = shr_a;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, cmp.lt};   // 0 or 1
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, cmp.ltu};  // 0 or 1
            default:  result = '0;                 // Unused encodings
        endcase
    end

    // --------------------
    // Checks
    // --------------------

    // Decode must never hand over one of the six unused encodings
    always_comb begin
        assert (alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                               ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU})
            else $error("exec_alu: illegal alu_op %0d", alu_op);
    end

endmodule

`default_nettype wire

// File: src/exec_cfu.sv
// Execute stage control flow unit
// Decides whether a branch or jump is taken, forms its target and
// holds the request to fetch until it is acknowledged

`default_nettype none

module exec_cfu import exec_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,                   // Sync, active low
    input  logic       s2_valid,                   // Decode has an instruction
    input  exec_req_t  s2_req,                     // The instruction itself
    input  cmp_flags_t cmp,                        // From the ALU
    input  xword_t     sum,                        // lhs + rhs from the ALU
    input  logic       accept,                     // Instruction leaves s2
    input  logic       flush,                      // Pipeline flush
    input  logic       cf_ack,                     // Fetch took the request
    output logic       cf_valid,                   // Request to fetch
    output xword_t     cf_target,                  // New fetch address
    output logic       taken,                      // Control flow changes
    output logic       cf_done                     // Nothing left to wait for
);

    logic   acked;                                 // Fetch already acknowledged
    xword_t pc_rel;                                // pc + imm

    // --------------------
    // Branch decision
    // --------------------

    always_comb begin
        case (s2_req.cfu_op)
            CFU_BEQ:  taken = cmp.eq;
            CFU_BNE:  taken = !cmp.eq;
            CFU_BLT:  taken = cmp.lt;
            CFU_BGE:  taken = !cmp.lt;
            CFU_BLTU: taken = cmp.ltu;
            CFU_BGEU: taken = !cmp.ltu;
            CFU_JAL,
            CFU_JALR: taken = 1'b1;                // Jumps always taken
            default:  taken = 1'b0;                // CFU_NONE
        endcase
    end

    // --------------------
    // Target
    // --------------------

    assign pc_rel = s2_req.pc + s2_req.imm;

    // jalr uses rs1 + imm from the ALU adder, low bit dropped
    assign cf_target = (s2_req.cfu_op == CFU_JALR) ? {sum[XLEN-1:1], 1'b0} : pc_rel;

    // --------------------
    // Request handshake
    // --------------------

    assign cf_valid = s2_valid && taken && !acked; // Once per instruction
    assign cf_done  = !taken || cf_ack || acked;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            acked <= 1'b0;
        end else if (accept || flush) begin
            acked <= 1'b0;                         // Next instruction starts clean
        end else if (cf_valid && cf_ack) begin
            acked <= 1'b1;                         // Wait for writeback space
        end
    end

    // --------------------
    // Checks
    // --------------------

    // Request holds, address unchanged, until fetch takes it
    a_cf_stable : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cf_valid && !cf_ack && !flush) |=> (cf_valid && $stable(cf_target)))
        else $error("exec_cfu: cf request dropped or changed before cf_ack");

    // Acked instruction stays in s2 until accepted, so it never asks twice
    a_cf_once : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (acked && !flush) |-> (s2_valid && taken))
        else $error("exec_cfu: acked instruction left s2 before it was accepted");

endmodule

`default_nettype wire

// File: src/exec_wb_reg.sv
// Execute to writeback pipeline register
// Holds one writeback packet, forms s2_ready and the accept event,
// and empties on consume or flush

`default_nettype none

module exec_wb_reg import exec_pkg::*; (
    input  logic    g_clk,
    input  logic    g_resetn,                      // Sync, active low
    input  logic    s2_valid,                      // Decode has an instruction
    input  logic    cf_done,                       // CFU has nothing pending
    input  logic    flush,                         // Drop held and incoming packet
    input  wb_pkt_t n_pkt,                         // Packet for the accepted instruction
    input  logic    s3_ready,                      // Writeback can take a packet
    output logic    s2_ready,                      // Execute can take an instruction
    output logic    accept,                        // Instruction moves into s3
    output logic    s3_valid,                      // Packet held
    output wb_pkt_t s3_pkt                         // Held packet
);

    logic s3_drain;                                // Held packet consumed this cycle

    // --------------------
    // Handshake
    // --------------------

    assign s3_drain = s3_valid && s3_ready;

    // Room when empty or emptying, and fetch already knows about any jump
    assign s2_ready = g_resetn && cf_done && (!s3_valid || s3_ready);  // Low in reset
    assign accept   = s2_valid && s2_ready;

    // --------------------
    // Register
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            s3_valid <= 1'b0;                      // Flush also drops an accept
        end else if (accept) begin
            s3_valid <= 1'b1;
        end else if (s3_drain) begin
            s3_valid <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            s3_pkt <= n_pkt;                       // Load the accepted packet
        end
    end

    // --------------------
    // Checks
    // --------------------

    // Stalled packet stays put for writeback
    a_s3_hold : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (s3_valid && !s3_ready && !flush) |=> (s3_valid && $stable(s3_pkt)))
        else $error("exec_wb_reg: s3 packet changed while stalled");

endmodule

`default_nettype wire

// File: src/core_pipe_exec.sv
// Execute stage top level
// Runs a decoded instruction through the ALU and CFU, talks to fetch
// about taken jumps and registers the writeback packet

`default_nettype none

module core_pipe_exec import exec_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,                    // Sync, active low
    input  logic      s2_flush,                    // Flush stage contents
    input  logic      s2_valid,                    // Decode -> execute valid
    input  exec_req_t s2_req,                      // Decoded instruction
    output logic      s2_ready,                    // Execute can accept
    output logic      cf_valid,                    // Control flow change
    output xword_t    cf_target,                   // Where to fetch from
    input  logic      cf_ack,                      // Fetch acknowledged
    output logic      s3_valid,                    // Packet for writeback
    input  logic      s3_ready,                    // Writeback can take it
    output wb_pkt_t   s3_pkt                       // Writeback packet
);

    // --------------------
    // Internal links
    // --------------------

    xword_t     alu_result;                        // Selected ALU result
    xword_t     alu_sum;                           // lhs + rhs
    cmp_flags_t cmp;                               // Comparison flags
    logic       taken;                             // Branch or jump taken
    logic       cf_done;                           // No fetch request pending
    logic       accept;                            // s2 -> s3 this cycle
    wb_pkt_t    n_pkt;                             // Packet being formed

    exec_alu exec_alu_i (
        .alu_op (s2_req.alu_op),
        .lhs    (s2_req.lhs),
        .rhs    (s2_req.rhs),
        .result (alu_result),
        .sum    (alu_sum),
        .cmp    (cmp)
    );

    exec_cfu exec_cfu_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s2_valid  (s2_valid),
        .s2_req    (s2_req),
        .cmp       (cmp),
        .sum       (alu_sum),
        .accept    (accept),
        .flush     (s2_flush),
        .cf_ack    (cf_ack),
        .cf_valid  (cf_valid),
        .cf_target (cf_target),
        .taken     (taken),
        .cf_done   (cf_done)
    );

    // --------------------
    // Writeback packet
    // --------------------

    assign n_pkt.pc       = s2_req.pc;
    assign n_pkt.rd       = s2_req.rd;
    assign n_pkt.wdata    = (s2_req.wb_src == WB_NPC) ? s2_req.npc : alu_result;  // Link
    assign n_pkt.cf_taken = taken;

    exec_wb_reg exec_wb_reg_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .s2_valid (s2_valid),
        .cf_done  (cf_done),
        .flush    (s2_flush),
        .n_pkt    (n_pkt),
        .s3_ready (s3_ready),
        .s2_ready (s2_ready),
        .accept   (accept),
        .s3_valid (s3_valid),
        .s3_pkt   (s3_pkt)
    );

endmodule

`default_nettype wire

// File: dv/tb_vectors.svh
// Execute stage test vectors
// One row per instruction with its expected packet, taken flag and
// fetch target, all worked out by hand

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct {
    exec_req_t req;                                // Driven on s2
    wb_pkt_t   pkt;                                // Expected on s3
    logic      taken;                              // Expect a cf request
    xword_t    target;                             // Expected cf_target
    logic      flush;                              // Flushed while waiting in s3
} row_t;

row_t tbl[$];

task automatic add_row(input xword_t pc, input int rd, input xword_t lhs, input xword_t rhs,
                       input xword_t imm, input alu_op_e alu_op, input cfu_op_e cfu_op,
                       input wb_src_e wb_src, input xword_t wdata, input int taken,
                       input xword_t target, input int flush);
    row_t r;
    r.req.pc       = pc;
    r.req.npc      = pc + 32'd4;                   // Sequential successor
    r.req.rd       = reg_addr_t'(rd);
    r.req.lhs      = lhs;
    r.req.rhs      = rhs;
    r.req.imm      = imm;
    r.req.alu_op   = alu_op;
    r.req.cfu_op   = cfu_op;
    r.req.wb_src   = wb_src;
    r.pkt.pc       = pc;
    r.pkt.rd       = reg_addr_t'(rd);
    r.pkt.wdata    = wdata;
    r.pkt.cf_taken = (taken != 0);
    r.taken        = (taken != 0);
    r.target       = target;
    r.flush        = (flush != 0);
    tbl.push_back(r);
endtask

task automatic load_table();
    // pc, rd, lhs, rhs, imm, alu_op, cfu_op, wb_src, wdata, taken, target, flush
    add_row('h100, 1, 5, 7, 0, ALU_ADD, CFU_NONE, WB_ALU, 'hC, 0, 0, 0);
    add_row('h104, 2, -1, 2, 0, ALU_ADD, CFU_NONE, WB_ALU, 1, 0, 0, 0);        // Wraps
    add_row('h108, 3, 'h10, 'h20, 0, ALU_SUB, CFU_NONE, WB_ALU, 'hFFFFFFF0, 0, 0, 0);
    add_row('h10C, 4, 'hF0F01234, 'h0FF0FF00, 0, ALU_AND, CFU_NONE, WB_ALU, 'h00F01200, 0, 0, 0);
    add_row('h110, 5, 'hF000000F, 'h0F0000F0, 0, ALU_OR, CFU_NONE, WB_ALU, 'hFF0000FF, 0, 0, 0);
    add_row('h114, 6, 'hAAAA5555, 'hFFFF0000, 0, ALU_XOR, CFU_NONE, WB_ALU, 'h55555555, 0, 0, 0);
    add_row('h118, 7, 3, 'h24, 0, ALU_SLL, CFU_NONE, WB_ALU, 'h30, 0, 0, 0);   // Shamt 4
    add_row('h11C, 8, 'h80000000, 31, 0, ALU_SRL, CFU_NONE, WB_ALU, 1, 0, 0, 0);
    add_row('h120, 9, 'h80000000, 4, 0, ALU_SRA, CFU_NONE, WB_ALU, 'hF8000000, 0, 0, 0);
    add_row('h124, 10, -2, 1, 0, ALU_SLT, CFU_NONE, WB_ALU, 1, 0, 0, 0);
    add_row('h128, 11, -2, 1, 0, ALU_SLTU, CFU_NONE, WB_ALU, 0, 0, 0, 0);
    // Branches, wdata is the ALU sum
    add_row('h12C, 0, 5, 5, 'h40, ALU_ADD, CFU_BEQ, WB_ALU, 'hA, 1, 'h16C, 0);
    add_row('h130, 0, 5, 6, 'h40, ALU_ADD, CFU_BEQ, WB_ALU, 'hB, 0, 0, 0);
    add_row('h134, 0, 1, 2, -16, ALU_ADD, CFU_BNE, WB_ALU, 3, 1, 'h124, 0);
    add_row('h138, 0, 7, 7, -16, ALU_ADD, CFU_BNE, WB_ALU, 'hE, 0, 0, 0);
    add_row('h13C, 0, -1, 1, 'h100, ALU_ADD, CFU_BLT, WB_ALU, 0, 1, 'h23C, 0);
    add_row('h140, 0, 1, -1, 'h100, ALU_ADD, CFU_BLT, WB_ALU, 0, 0, 0, 0);
    add_row('h144, 0, 1, -1, 8, ALU_ADD, CFU_BGE, WB_ALU, 0, 1, 'h14C, 0);
    add_row('h148, 0, -1, 1, 8, ALU_ADD, CFU_BGE, WB_ALU, 0, 0, 0, 0);
    add_row('h14C, 0, 1, -1, 'h20, ALU_ADD, CFU_BLTU, WB_ALU, 0, 1, 'h16C, 0);
    add_row('h150, 0, -1, 1, 'h20, ALU_ADD, CFU_BLTU, WB_ALU, 0, 0, 0, 0);
    add_row('h154, 0, -1, 1, -256, ALU_ADD, CFU_BGEU, WB_ALU, 0, 1, 'h54, 0);
    add_row('h158, 0, 1, -1, -256, ALU_ADD, CFU_BGEU, WB_ALU, 0, 0, 0, 0);
    // Jumps link npc, jalr sums are odd
    add_row('h15C, 1, 0, 0, 'h400, ALU_ADD, CFU_JAL, WB_NPC, 'h160, 1, 'h55C, 0);
    add_row('h160, 5, 'h2001, 'h10, 'h10, ALU_ADD, CFU_JALR, WB_NPC, 'h164, 1, 'h2010, 0);
    add_row('h164, 6, 'h80000003, -4, -4, ALU_ADD, CFU_JALR, WB_NPC, 'h168, 1, 'h7FFFFFFE, 0);
    // Flushed out of s3, then normal traffic again
    add_row('h168, 7, 'h11, 'h22, 0, ALU_ADD, CFU_NONE, WB_ALU, 'h33, 0, 0, 1);
    add_row('h16C, 8, 0, 0, 'h10, ALU_ADD, CFU_JAL, WB_NPC, 'h170, 1, 'h17C, 1);
    add_row('h170, 9, 'h12345678, -1, 0, ALU_XOR, CFU_NONE, WB_ALU, 'hEDCBA987, 0, 0, 0);
    add_row('h174, 10, 0, 1, 0, ALU_SUB, CFU_NONE, WB_ALU, -1, 0, 0, 0);
endtask

`endif

// File: dv/tb_core_pipe_exec.sv
// Execute stage testbench
// Drives the vector table from decode, answers fetch and writeback
// with random delays and checks every cf request and s3 packet

`default_nettype none

module tb_core_pipe_exec import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int        CLK_PERIOD = 100;        // ns
    localparam int        RST_CYCLES = 4;
    localparam int        TIMEOUT    = 200;        // Cycles per wait
    localparam bit [31:0] SEED       = 32'hf438_de48;

    logic      g_clk;
    logic      g_resetn;
    logic      s2_flush;
    logic      s2_valid;
    exec_req_t s2_req;
    logic      s2_ready;
    logic      cf_valid;
    xword_t    cf_target;
    logic      cf_ack;
    logic      s3_valid;
    logic      s3_ready;
    wb_pkt_t   s3_pkt;

    bit        hold_s3;                            // Keep writeback stalled
    bit        timed_out;
    int        errors;
    int        tests_run;
    int        tests_passed;
    int        row_errs[];                         // Errors per table row
    int        exp_q[$];                           // Rows still owed to writeback

    `include "tb_vectors.svh"

    core_pipe_exec core_pipe_exec_i (.*);

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // --------------------
    // Checks and report
    // --------------------

    task automatic fail_row(input int i, input string msg);
        $display("error at %0t: test %0d %s", $time, i, msg);
        row_errs[i]++;
        errors++;
    endtask

    task automatic check_wb(input int i, input wb_pkt_t got, input wb_pkt_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: test %0d s3_pkt pc %h rd %0d wdata %h taken %b, %s",
                     $time, i, got.pc, got.rd, got.wdata, got.cf_taken, "expected");
            $display("    pc %h rd %0d wdata %h taken %b", exp.pc, exp.rd, exp.wdata,
                     exp.cf_taken);
            row_errs[i]++;
            errors++;
        end
    endtask

    task automatic check_cf(input int i, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: test %0d cf_target %h, expected %h", $time, i, got, exp);
            row_errs[i]++;
            errors++;
        end
    endtask

    task automatic report_row(input int i, input string how);
        tests_run++;
        if (row_errs[i] == 0) begin
            tests_passed++;
        end
        $display("test %0d %s %s %s: %s", i, tbl[i].req.alu_op.name(),
                 tbl[i].req.cfu_op.name(), how, (row_errs[i] == 0) ? "passed" : "FAILED");
    endtask

    // --------------------
    // Driver steps
    // --------------------

    task automatic wait_s3_empty();
        int cyc;
        for (cyc = 0; cyc < TIMEOUT; cyc++) begin
            @(posedge g_clk);
            if (!s3_valid) break;
        end
        if (cyc == TIMEOUT) begin
            $display("timeout: s3 never drained before a flush test");
            timed_out = 1'b1;
        end
    endtask

    // Present one row, watch fetch traffic until the accept edge
    task automatic run_row(input int i);
        int   cyc;
        bit   hs;                                  // cf handshake seen
        row_t r;
        r  = tbl[i];
        hs = 1'b0;
        s2_req   <= r.req;
        s2_valid <= 1'b1;
        for (cyc = 0; cyc < TIMEOUT; cyc++) begin
            @(posedge g_clk);
            if (cf_valid && !r.taken) begin
                fail_row(i, "cf_valid raised for a not-taken instruction");
            end else if (cf_valid && hs) begin
                fail_row(i, "cf_valid raised a second time");
            end else if (cf_valid) begin
                check_cf(i, cf_target, r.target);  // Every cycle of the wait
            end
            if (cf_valid && cf_ack) hs = 1'b1;
            if (s2_ready) begin
                if (r.taken && !hs) fail_row(i, "taken instruction accepted before cf_ack");
                break;
            end
        end
        if (cyc == TIMEOUT) begin
            $display("timeout: test %0d was never accepted", i);
            timed_out = 1'b1;
        end
    endtask

    task automatic flush_row(input int i);
        s2_valid <= 1'b0;
        s2_flush <= 1'b1;
        @(posedge g_clk);                          // Flush edge
        if (!s3_valid) fail_row(i, "packet was not waiting in s3 when flushed");
        s2_flush <= 1'b0;
        hold_s3  <= 1'b0;
        @(posedge g_clk);
        if (s3_valid) fail_row(i, "flushed packet still in s3");
        report_row(i, "flushed");
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin : driver
        int i;
        int cyc;
        void'($urandom(SEED));
        g_resetn <= 1'b0;
        s2_flush <= 1'b0;
        s2_valid <= 1'b0;
        s2_req   <= '0;
        load_table();
        row_errs = new[tbl.size()];
        for (i = 0; i < tbl.size(); i++) begin
            if (!tbl[i].flush) exp_q.push_back(i);
        end
        repeat (RST_CYCLES) @(posedge g_clk);
        if (s3_valid || cf_valid || s2_ready) begin
            $display("error at %0t: s3_valid, cf_valid or s2_ready high in reset", $time);
            errors++;
        end
        g_resetn <= 1'b1;
        for (i = 0; i < tbl.size() && !timed_out; i++) begin
            if (tbl[i].flush) begin
                s2_valid <= 1'b0;
                wait_s3_empty();
                hold_s3 <= 1'b1;                   // Packet must sit in s3
                @(posedge g_clk);
            end
            if (!timed_out) run_row(i);
            if (tbl[i].flush && !timed_out) flush_row(i);
        end
        s2_valid <= 1'b0;
        for (cyc = 0; cyc < TIMEOUT && exp_q.size() != 0; cyc++) begin
            @(posedge g_clk);
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d packets never reached writeback", exp_q.size());
            timed_out = 1'b1;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // --------------------
    // Responders and monitor
    // --------------------

    initial begin : fetch_responder
        int wait_cyc;
        wait_cyc = 0;
        cf_ack <= 1'b0;
        forever begin
            @(posedge g_clk);
            if (cf_valid && cf_ack) begin
                cf_ack   <= 1'b0;
                wait_cyc = $urandom % 4;           // Delay for the next request
            end else if (cf_valid && wait_cyc == 0) begin
                cf_ack <= 1'b1;
            end else if (cf_valid) begin
                wait_cyc--;
            end else begin
                cf_ack <= 1'b0;
            end
        end
    end

    initial begin : wb_responder
        int stall;
        stall = 0;
        s3_ready <= 1'b0;
        forever begin
            @(posedge g_clk);
            if (hold_s3) begin
                s3_ready <= 1'b0;
            end else if (stall > 0) begin
                s3_ready <= 1'b0;
                stall--;
            end else if ($urandom % 3 == 0) begin
                stall = 1 + $urandom % 6;          // Random back-pressure stretch
                s3_ready <= 1'b0;
            end else begin
                s3_ready <= 1'b1;
            end
        end
    end

    always @(posedge g_clk) begin : wb_monitor
        int idx;
        if (g_resetn && s3_valid && s3_ready) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: writeback packet with no instruction outstanding", $time);
                errors++;
            end else begin
                idx = exp_q.pop_front();           // Table order
                check_wb(idx, s3_pkt, tbl[idx].pkt);
                report_row(idx, "delivered");
            end
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+dv
src/exec_pkg.sv
src/exec_alu.sv
src/exec_cfu.sv
src/exec_wb_reg.sv
src/core_pipe_exec.sv
dv/tb_core_pipe_exec.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_core_pipe_exec -o sim_exec

./obj_dir/sim_exec | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
